// File: hdl/isaPkg.sv
package isaPkg;

   typedef logic [31:0] dataWord;
   typedef logic [4:0]  regIndex;
   typedef logic [5:0]  opcodeField;
   typedef logic [5:0]  functField;

   // Primary opcodes
   localparam opcodeField opcodeRFormat = 6'h00;
   localparam opcodeField opcodeAddi    = 6'h03;
   localparam opcodeField opcodeSubi    = 6'h02;
   localparam opcodeField opcodeXori    = 6'h01;
   localparam opcodeField opcodeAndi    = 6'h0F;
   localparam opcodeField opcodeOri     = 6'h0C;
   localparam opcodeField opcodeSw      = 6'h1F;
   localparam opcodeField opcodeLw      = 6'h1E;
   localparam opcodeField opcodeBeq     = 6'h30;
   localparam opcodeField opcodeBne     = 6'h31;

   // R-format function codes
   localparam functField functAdd = 6'h03;
   localparam functField functSub = 6'h02;
   localparam functField functXor = 6'h01;
   localparam functField functAnd = 6'h07;
   localparam functField functOr  = 6'h04;
   localparam functField functSlt = 6'h36;
   localparam functField functSle = 6'h37;

   // Instruction fields
   localparam int opcodeMsb = 31;
   localparam int opcodeLsb = 26;
   localparam int rsMsb     = 25;
   localparam int rsLsb     = 21;
   localparam int rtMsb     = 20;
   localparam int rtLsb     = 16;
   localparam int rdMsb     = 15;
   localparam int rdLsb     = 11;
   localparam int immMsb    = 15;
   localparam int immLsb    = 0;
   localparam int functMsb  = 5;
   localparam int functLsb  = 0;

   localparam dataWord instrBytes = 32'd4;

endpackage

// File: hdl/pipePkg.sv
package pipePkg;

   typedef enum logic [2:0] {
      opAdd,
      opSub,
      opXor,
      opAnd,
      opOr,
      opSlt,
      opSle
   } aluOp;

   // Decode to fetch, offset counted in words
   typedef struct packed {
      logic            taken;
      isaPkg::dataWord offset;
   } branchCtrl;

   typedef struct packed {
      aluOp            op;
      isaPkg::dataWord operandA;
      isaPkg::dataWord operandB;
      isaPkg::dataWord storeData;
      isaPkg::regIndex destReg;
      logic            regWrite;
      logic            memRead;
      logic            memWrite;
   } idExBundle;

   typedef struct packed {
      isaPkg::dataWord aluResult;
      isaPkg::dataWord storeData;
      isaPkg::regIndex destReg;
      logic            regWrite;
      logic            memRead;
      logic            memWrite;
   } exMemBundle;

   typedef struct packed {
      logic            enable;
      isaPkg::regIndex index;
      isaPkg::dataWord value;
   } regWritePort;

endpackage

// File: hdl/fetchStage.sv
`timescale 1ns/10ps

module fetchStage #(
   parameter isaPkg::dataWord resetAddr = '0
) (
   input  logic               clk,
   input  logic               reset,
   input  pipePkg::branchCtrl branch,
   output isaPkg::dataWord    instrAddr,
   input  isaPkg::dataWord    instrIn,
   output isaPkg::dataWord    instr,
   output isaPkg::dataWord    nextPc
);

   isaPkg::dataWord seqAddr;
   isaPkg::dataWord branchTarget;

   assign seqAddr = instrAddr + isaPkg::instrBytes;

   // Relative to the address after the branch
   assign branchTarget = nextPc + (branch.offset << 2);

   always_ff @(posedge clk) begin
      if (reset) begin
         instrAddr <= resetAddr;
      end else if (branch.taken) begin
         instrAddr <= branchTarget;
      end else begin
         instrAddr <= seqAddr;
      end
   end

   // Fetch/decode register
   always_ff @(posedge clk) begin
      nextPc <= seqAddr;
      if (reset) begin
         // All zero decodes as NOP
         instr <= '0;
      end else begin
         instr <= instrIn;
      end
   end

endmodule

// File: hdl/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
   input  logic               clk,
   input  logic               reset,
   input  isaPkg::dataWord    instr,
   input  isaPkg::dataWord    nextPc,
   output isaPkg::regIndex    readA,
   output isaPkg::regIndex    readB,
   input  isaPkg::dataWord    dataA,
   input  isaPkg::dataWord    dataB,
   output pipePkg::branchCtrl branch,
   output pipePkg::idExBundle toExecute
);

   isaPkg::opcodeField opcode;
   isaPkg::functField  funct;
   isaPkg::regIndex    rd;
   isaPkg::dataWord    immExt;
   pipePkg::aluOp      op;
   logic               useImm;
   logic               destIsRt;
   logic               regWrite;
   logic               memRead;
   logic               memWrite;
   logic               isBeq;
   logic               isBne;

   assign opcode = instr[isaPkg::opcodeMsb:isaPkg::opcodeLsb];
   assign funct  = instr[isaPkg::functMsb:isaPkg::functLsb];
   assign readA  = instr[isaPkg::rsMsb:isaPkg::rsLsb];
   assign readB  = instr[isaPkg::rtMsb:isaPkg::rtLsb];
   assign rd     = instr[isaPkg::rdMsb:isaPkg::rdLsb];
   assign immExt = {{16{instr[isaPkg::immMsb]}}, instr[isaPkg::immMsb:isaPkg::immLsb]};

   always_comb begin
      op       = pipePkg::opAdd;
      useImm   = 1'b1;
      destIsRt = 1'b1;
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      isBeq    = 1'b0;
      isBne    = 1'b0;
      case (opcode)
         isaPkg::opcodeAddi: regWrite = 1'b1;
         isaPkg::opcodeSubi: begin
            op       = pipePkg::opSub;
            regWrite = 1'b1;
         end
         isaPkg::opcodeXori: begin
            op       = pipePkg::opXor;
            regWrite = 1'b1;
         end
         isaPkg::opcodeAndi: begin
            op       = pipePkg::opAnd;
            regWrite = 1'b1;
         end
         isaPkg::opcodeOri: begin
            op       = pipePkg::opOr;
            regWrite = 1'b1;
         end
         isaPkg::opcodeLw: begin
            regWrite = 1'b1;
            memRead  = 1'b1;
         end
         isaPkg::opcodeSw:  memWrite = 1'b1;
         isaPkg::opcodeBeq: isBeq = 1'b1;
         isaPkg::opcodeBne: isBne = 1'b1;
         isaPkg::opcodeRFormat: begin
            useImm   = 1'b0;
            destIsRt = 1'b0;
            regWrite = 1'b1;
            case (funct)
               isaPkg::functAdd: op = pipePkg::opAdd;
               isaPkg::functSub: op = pipePkg::opSub;
               isaPkg::functXor: op = pipePkg::opXor;
               isaPkg::functAnd: op = pipePkg::opAnd;
               isaPkg::functOr:  op = pipePkg::opOr;
               isaPkg::functSlt: op = pipePkg::opSlt;
               isaPkg::functSle: op = pipePkg::opSle;
               default:          regWrite = 1'b0;
            endcase
         end
         default: ;
      endcase
   end

   // Resolved here so only the delay slot is in flight
   assign branch.taken  = (isBeq && dataA == dataB) || (isBne && dataA != dataB);
   assign branch.offset = immExt;

   // Decode/execute register
   always_ff @(posedge clk) begin
      toExecute.op        <= op;
      toExecute.operandA  <= dataA;
      toExecute.operandB  <= useImm ? immExt : dataB;
      toExecute.storeData <= dataB;
      toExecute.destReg   <= destIsRt ? readB : rd;
      if (reset) begin
         toExecute.regWrite <= 1'b0;
         toExecute.memRead  <= 1'b0;
         toExecute.memWrite <= 1'b0;
      end else begin
         toExecute.regWrite <= regWrite;
         toExecute.memRead  <= memRead;
         toExecute.memWrite <= memWrite;
      end
   end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/10ps

module regFile (
   input  logic                 clk,
   input  logic                 reset,
   input  isaPkg::regIndex      readA,
   input  isaPkg::regIndex      readB,
   output isaPkg::dataWord      dataA,
   output isaPkg::dataWord      dataB,
   input  pipePkg::regWritePort write
);

   isaPkg::dataWord regs [31:1];

   function automatic isaPkg::dataWord readPort(isaPkg::regIndex idx);
      if (idx == '0) begin
         return '0;
      end else if (write.enable && write.index == idx) begin
         // Same-cycle write seen by the reader
         return write.value;
      end else begin
         return regs[idx];
      end
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (write.enable && write.index != '0) begin
         regs[write.index] <= write.value;
      end
   end

   always_comb begin
      dataA = readPort(readA);
      dataB = readPort(readB);
   end

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/10ps

module executeStage (
   input  logic                clk,
   input  logic                reset,
   input  pipePkg::idExBundle  fromDecode,
   output pipePkg::exMemBundle toWriteback,
   output isaPkg::dataWord     dataAddr,
   output isaPkg::dataWord     writeData,
   output logic                storeEn
);

   isaPkg::dataWord a;
   isaPkg::dataWord b;
   isaPkg::dataWord aluResult;

   assign a = fromDecode.operandA;
   assign b = fromDecode.operandB;

   // Comparisons are unsigned
   always_comb begin
      case (fromDecode.op)
         pipePkg::opAdd: aluResult = a + b;
         pipePkg::opSub: aluResult = a - b;
         pipePkg::opXor: aluResult = a ^ b;
         pipePkg::opAnd: aluResult = a & b;
         pipePkg::opOr:  aluResult = a | b;
         pipePkg::opSlt: aluResult = {31'b0, a < b};
         pipePkg::opSle: aluResult = {31'b0, a <= b};
         default:        aluResult = a + b;
      endcase
   end

   // Execute/memory register
   always_ff @(posedge clk) begin
      toWriteback.aluResult <= aluResult;
      toWriteback.storeData <= fromDecode.storeData;
      toWriteback.destReg   <= fromDecode.destReg;
      if (reset) begin
         toWriteback.regWrite <= 1'b0;
         toWriteback.memRead  <= 1'b0;
         toWriteback.memWrite <= 1'b0;
      end else begin
         toWriteback.regWrite <= fromDecode.regWrite;
         toWriteback.memRead  <= fromDecode.memRead;
         toWriteback.memWrite <= fromDecode.memWrite;
      end
   end

   // Data port straight off the register
   assign dataAddr  = toWriteback.aluResult;
   assign writeData = toWriteback.storeData;
   assign storeEn   = toWriteback.memWrite;

endmodule

// File: hdl/writebackStage.sv
`timescale 1ns/10ps

module writebackStage (
   input  logic                 clk,
   input  logic                 reset,
   input  pipePkg::exMemBundle  fromExecute,
   input  isaPkg::dataWord      readData,
   output pipePkg::regWritePort write
);

   isaPkg::dataWord loadData;
   isaPkg::dataWord aluResult;
   isaPkg::regIndex destReg;
   logic            regWrite;
   logic            memRead;

   // Memory/writeback register
   always_ff @(posedge clk) begin
      loadData  <= readData;
      aluResult <= fromExecute.aluResult;
      destReg   <= fromExecute.destReg;
      if (reset) begin
         regWrite <= 1'b0;
         memRead  <= 1'b0;
      end else begin
         regWrite <= fromExecute.regWrite;
         memRead  <= fromExecute.memRead;
      end
   end

   always_comb begin
      write.enable = regWrite;
      write.index  = destReg;
      write.value  = memRead ? loadData : aluResult;
   end

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/10ps

module cpuTop #(
   parameter isaPkg::dataWord resetAddr = '0
) (
   input  logic            clk,
   input  logic            reset,
   output isaPkg::dataWord instrAddr,
   input  isaPkg::dataWord instr,
   output isaPkg::dataWord dataAddr,
   output isaPkg::dataWord writeData,
   output logic            storeEn,
   input  isaPkg::dataWord readData
);

   pipePkg::branchCtrl   branch;
   isaPkg::dataWord      decodeInstr;
   isaPkg::dataWord      decodeNextPc;
   isaPkg::regIndex      readA;
   isaPkg::regIndex      readB;
   isaPkg::dataWord      dataA;
   isaPkg::dataWord      dataB;
   pipePkg::idExBundle   idEx;
   pipePkg::exMemBundle  exMem;
   pipePkg::regWritePort rfWrite;

   // Input side
   fetchStage #(
      .resetAddr(resetAddr)
   ) i_fetchStage (
      .clk(clk),
      .reset(reset),
      .branch(branch),
      .instrAddr(instrAddr),
      .instrIn(instr),
      .instr(decodeInstr),
      .nextPc(decodeNextPc)
   );

   decodeStage i_decodeStage (
      .clk(clk),
      .reset(reset),
      .instr(decodeInstr),
      .nextPc(decodeNextPc),
      .readA(readA),
      .readB(readB),
      .dataA(dataA),
      .dataB(dataB),
      .branch(branch),
      .toExecute(idEx)
   );

   regFile i_regFile (
      .clk(clk),
      .reset(reset),
      .readA(readA),
      .readB(readB),
      .dataA(dataA),
      .dataB(dataB),
      .write(rfWrite)
   );

   executeStage i_executeStage (
      .clk(clk),
      .reset(reset),
      .fromDecode(idEx),
      .toWriteback(exMem),
      .dataAddr(dataAddr),
      .writeData(writeData),
      .storeEn(storeEn)
   );

   // Output side
   writebackStage i_writebackStage (
      .clk(clk),
      .reset(reset),
      .fromExecute(exMem),
      .readData(readData),
      .write(rfWrite)
   );

endmodule

// File: bench/cpuTop_chk.sv
`timescale 1ns/10ps

module cpuTop_chk (
   input logic            clk,
   input logic            reset,
   input isaPkg::dataWord instrAddr,
   input logic            storeEn
);

   int failCount = 0;

   // Covers the reset cycles and the first cycle after release
   storeLowAroundReset: assert property (@(posedge clk) reset |=> !storeEn)
      else begin
         failCount++;
         $error("storeEn high during or just after reset");
      end

   fetchAligned: assert property (@(posedge clk) !reset |-> instrAddr[1:0] == 2'b00)
      else begin
         failCount++;
         $error("instrAddr not word aligned");
      end

   storeKnown: assert property (@(posedge clk) !reset |-> !$isunknown(storeEn))
      else begin
         failCount++;
         $error("storeEn is unknown");
      end

endmodule

bind cpuTop cpuTop_chk i_cpuTop_chk (
   .clk(clk),
   .reset(reset),
   .instrAddr(instrAddr),
   .storeEn(storeEn)
);

// File: bench/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

   localparam int memWords   = 1024;
   localparam int cycleLimit = 2000;

   logic            clk;
   logic            reset;
   isaPkg::dataWord instrAddr;
   isaPkg::dataWord instr;
   isaPkg::dataWord dataAddr;
   isaPkg::dataWord writeData;
   isaPkg::dataWord readData;
   logic            storeEn;

   isaPkg::dataWord imem [memWords];
   isaPkg::dataWord dmem [memWords];
   isaPkg::dataWord prog [$];
   isaPkg::dataWord fetchLog [$];
   isaPkg::dataWord storeAddrLog [$];
   isaPkg::dataWord storeDataLog [$];
   isaPkg::dataWord expAddr [$];
   isaPkg::dataWord expData [$];
   int              cycles = 0;

   cpuTop #(
      .resetAddr('0)
   ) i_cpuTop (
      .clk(clk),
      .reset(reset),
      .instrAddr(instrAddr),
      .instr(instr),
      .dataAddr(dataAddr),
      .writeData(writeData),
      .storeEn(storeEn),
      .readData(readData)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Memories answer within the cycle
   assign instr    = imem[instrAddr[11:2]];
   assign readData = dmem[dataAddr[11:2]];

   function automatic isaPkg::dataWord fillWord(int idx);
      return (isaPkg::dataWord'(idx) * 32'h9E3779B1) ^ 32'h5A5A0000;
   endfunction

   function automatic isaPkg::dataWord signExtend(logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   function automatic isaPkg::dataWord encodeImm(isaPkg::opcodeField op, int rt, int rs, int imm);
      return {op, isaPkg::regIndex'(rs), isaPkg::regIndex'(rt), 16'(imm)};
   endfunction

   function automatic isaPkg::dataWord encodeReg(isaPkg::functField fn, int rd, int rs, int rt);
      return {isaPkg::opcodeRFormat, isaPkg::regIndex'(rs), isaPkg::regIndex'(rt),
              isaPkg::regIndex'(rd), 5'b0, fn};
   endfunction

   // Data memory is refilled with its pattern on every reset
   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < memWords; i++) begin
            dmem[i] <= fillWord(i);
         end
      end else if (storeEn) begin
         dmem[dataAddr[11:2]] <= writeData;
      end
   end

   always @(negedge clk) begin
      if (reset) begin
         fetchLog.delete();
         storeAddrLog.delete();
         storeDataLog.delete();
      end else begin
         fetchLog.push_back(instrAddr);
         if (storeEn) begin
            storeAddrLog.push_back(dataAddr);
            storeDataLog.push_back(writeData);
         end
      end
   end

   task automatic reportFailure(string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped");
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         reportFailure("Timeout: the tests did not finish within the cycle limit");
      end
   end

   task automatic checkFetch(isaPkg::dataWord expected, isaPkg::dataWord actual);
      if (actual !== expected) begin
         reportFailure($sformatf("** Error instrAddr: expected %08h, got %08h",
                                 expected, actual));
      end
   endtask

   task automatic checkStore(isaPkg::dataWord expA, isaPkg::dataWord expD,
                             isaPkg::dataWord gotA, isaPkg::dataWord gotD);
      if (gotA !== expA) begin
         reportFailure($sformatf("** Error dataAddr: expected %08h, got %08h", expA, gotA));
      end
      if (gotD !== expD) begin
         reportFailure($sformatf("** Error writeData at %08h: expected %08h, got %08h",
                                 expA, expD, gotD));
      end
   endtask

   task automatic expectStore(isaPkg::dataWord addr, isaPkg::dataWord data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic compareStores();
      if (storeAddrLog.size() != expAddr.size()) begin
         reportFailure($sformatf("Wrong number of stores: expected %0d, saw %0d",
                                 expAddr.size(), storeAddrLog.size()));
      end
      for (int i = 0; i < expAddr.size(); i++) begin
         checkStore(expAddr[i], expData[i], storeAddrLog[i], storeDataLog[i]);
      end
   endtask

   // Three NOPs keep each result clear of its consumers
   task automatic emit(isaPkg::dataWord w);
      prog.push_back(w);
      repeat (3) prog.push_back('0);
   endtask

   task automatic startTest();
      prog.delete();
      expAddr.delete();
      expData.delete();
   endtask

   task automatic runProgram();
      isaPkg::dataWord endAddr;
      endAddr = isaPkg::dataWord'((prog.size() + 6) * 4);
      @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < memWords; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : '0;
      end
      repeat (7) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      while (instrAddr < endAddr) begin
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic testReset();
      startTest();
      repeat (12) prog.push_back('0);
      runProgram();
      for (int i = 0; i < 8; i++) begin
         checkFetch(isaPkg::dataWord'(i * 4), fetchLog[i]);
      end
      compareStores();
   endtask

   task automatic testArith();
      logic [15:0]     immA;
      logic [15:0]     immB;
      logic [15:0]     immC;
      isaPkg::dataWord a;
      isaPkg::dataWord b;
      isaPkg::dataWord c;
      isaPkg::dataWord results [10];
      startTest();
      immA = 16'($urandom);
      immB = 16'($urandom);
      immC = 16'($urandom);
      a = signExtend(immA);
      b = signExtend(immB);
      c = signExtend(immC);
      emit(encodeImm(isaPkg::opcodeAddi, 1, 0, immA));
      emit(encodeImm(isaPkg::opcodeAddi, 2, 0, immB));
      emit(encodeReg(isaPkg::functAdd, 3, 1, 2));
      emit(encodeReg(isaPkg::functSub, 4, 1, 2));
      emit(encodeReg(isaPkg::functXor, 5, 1, 2));
      emit(encodeReg(isaPkg::functAnd, 6, 1, 2));
      emit(encodeReg(isaPkg::functOr, 7, 1, 2));
      emit(encodeImm(isaPkg::opcodeAddi, 8, 1, immC));
      emit(encodeImm(isaPkg::opcodeSubi, 9, 1, immC));
      emit(encodeImm(isaPkg::opcodeXori, 10, 1, immC));
      emit(encodeImm(isaPkg::opcodeAndi, 11, 1, immC));
      emit(encodeImm(isaPkg::opcodeOri, 12, 1, immC));
      results = '{a + b, a - b, a ^ b, a & b, a | b, a + c, a - c, a ^ c, a & c, a | c};
      for (int k = 0; k < 10; k++) begin
         emit(encodeImm(isaPkg::opcodeSw, 3 + k, 0, 16'h100 + 4 * k));
         expectStore(isaPkg::dataWord'(32'h100 + 4 * k), results[k]);
      end
      runProgram();
      compareStores();
   endtask

   task automatic testCompare();
      isaPkg::dataWord vals [5];
      int              pairA [3];
      int              pairB [3];
      startTest();
      vals = '{32'h0, 32'h5, 32'h5, 32'h3, signExtend(16'h8000)};
      // Equal pair, then small against a large unsigned value both ways
      pairA = '{1, 3, 4};
      pairB = '{2, 4, 3};
      for (int r = 1; r < 5; r++) begin
         emit(encodeImm(isaPkg::opcodeAddi, r, 0, vals[r][15:0]));
      end
      for (int p = 0; p < 3; p++) begin
         emit(encodeReg(isaPkg::functSlt, 10 + 2 * p, pairA[p], pairB[p]));
         emit(encodeReg(isaPkg::functSle, 11 + 2 * p, pairA[p], pairB[p]));
      end
      for (int p = 0; p < 3; p++) begin
         emit(encodeImm(isaPkg::opcodeSw, 10 + 2 * p, 0, 16'h180 + 8 * p));
         emit(encodeImm(isaPkg::opcodeSw, 11 + 2 * p, 0, 16'h184 + 8 * p));
         expectStore(isaPkg::dataWord'(32'h180 + 8 * p),
                     (vals[pairA[p]] < vals[pairB[p]]) ? 32'd1 : 32'd0);
         expectStore(isaPkg::dataWord'(32'h184 + 8 * p),
                     (vals[pairA[p]] <= vals[pairB[p]]) ? 32'd1 : 32'd0);
      end
      runProgram();
      compareStores();
   endtask

   task automatic testLoad();
      isaPkg::dataWord base;
      isaPkg::dataWord first;
      isaPkg::dataWord second;
      startTest();
      base = 32'h200;
      first = fillWord(int'((base + signExtend(16'd8)) >> 2));
      second = fillWord(int'((base + signExtend(16'hFFFC)) >> 2));
      emit(encodeImm(isaPkg::opcodeAddi, 1, 0, base[15:0]));
      emit(encodeImm(isaPkg::opcodeLw, 2, 1, 8));
      emit(encodeImm(isaPkg::opcodeLw, 3, 1, -4));
      emit(encodeReg(isaPkg::functAdd, 4, 2, 3));
      emit(encodeImm(isaPkg::opcodeSw, 4, 1, 16'h10));
      emit(encodeImm(isaPkg::opcodeSw, 2, 1, 16'h14));
      expectStore(base + 32'h10, first + second);
      expectStore(base + 32'h14, first);
      runProgram();
      compareStores();
   endtask

   task automatic testBranch();
      isaPkg::opcodeField ops [4];
      int                 rsB [4];
      logic               taken [4];
      isaPkg::dataWord    branchAt [4];
      int                 hit;
      startTest();
      ops = '{isaPkg::opcodeBeq, isaPkg::opcodeBne, isaPkg::opcodeBeq, isaPkg::opcodeBne};
      rsB = '{2, 3, 3, 2};
      taken = '{1'b1, 1'b1, 1'b0, 1'b0};
      emit(encodeImm(isaPkg::opcodeAddi, 1, 0, 7));
      emit(encodeImm(isaPkg::opcodeAddi, 2, 0, 7));
      emit(encodeImm(isaPkg::opcodeAddi, 3, 0, 9));
      for (int g = 0; g < 4; g++) begin
         branchAt[g] = isaPkg::dataWord'(prog.size() * 4);
         prog.push_back(encodeImm(ops[g], rsB[g], 1, 2));
         // Delay slot, next instruction, branch target
         for (int m = 0; m < 3; m++) begin
            prog.push_back(encodeImm(isaPkg::opcodeAddi, 10 + 3 * g + m, 0, 16 * g + m + 1));
         end
      end
      repeat (3) prog.push_back('0);
      for (int g = 0; g < 4; g++) begin
         for (int m = 0; m < 3; m++) begin
            emit(encodeImm(isaPkg::opcodeSw, 10 + 3 * g + m, 0, 16'h300 + 4 * (3 * g + m)));
            expectStore(isaPkg::dataWord'(32'h300 + 4 * (3 * g + m)),
                        (taken[g] && m == 1) ? 32'd0 : isaPkg::dataWord'(16 * g + m + 1));
         end
      end
      runProgram();
      for (int g = 0; g < 4; g++) begin
         hit = -1;
         for (int j = fetchLog.size() - 3; j >= 0; j--) begin
            if (fetchLog[j] == branchAt[g]) begin
               hit = j;
            end
         end
         if (hit < 0) begin
            reportFailure($sformatf("Branch at %08h was never fetched", branchAt[g]));
         end
         checkFetch(branchAt[g] + 4, fetchLog[hit + 1]);
         checkFetch(branchAt[g] + (taken[g] ? 32'd12 : 32'd8), fetchLog[hit + 2]);
      end
      compareStores();
   endtask

   initial begin
      reset = 1'b1;
      void'($urandom(32'h20c0d7bd));
      for (int i = 0; i < memWords; i++) begin
         imem[i] = '0;
      end
      testReset();
      testArith();
      testCompare();
      testLoad();
      testBranch();
      if (i_cpuTop.i_cpuTop_chk.failCount == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         reportFailure("Bound assertions failed during the run");
      end
   end

endmodule

// File: compile.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/writebackStage.sv
hdl/cpuTop.sv
bench/cpuTop_chk.sv
bench/cpuTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module cpuTb -f compile.f -o cpuTb
	./obj_dir/cpuTb

clean:
	rm -rf obj_dir
